//--- build.f
design/sb_pkg.sv
design/sb_prio_select.sv
design/sb_queue_ctrl.sv
design/sb_entry_table.sv
design/sb_clobber.sv
design/sb_operand_fwd.sv
design/scoreboard_top.sv
verif/sb_asserts.sv
verif/tb_scoreboard.sv

//--- verif/tb_scoreboard.sv
`timescale 1ns/1ns

module tb_scoreboard;

  logic                                              clk_i;
  logic                                              rst_ni;
  logic                                              flush_i;
  logic                                              flush_unissued_i;
  logic                                              decoded_valid_i;
  logic [sb_pkg::REG_ADDR_W-1:0]                     decoded_rd_i;
  logic [sb_pkg::FU_W-1:0]                           decoded_fu_i;
  logic                                              decoded_ack_o;
  logic                                              issue_valid_o;
  logic                                              issue_ack_i;
  logic [sb_pkg::IDX_W-1:0]                          issue_trans_id_o;
  logic                                              sb_full_o;
  logic [sb_pkg::NR_WB_PORTS-1:0]                    wb_valid_i;
  logic [sb_pkg::NR_WB_PORTS-1:0][sb_pkg::IDX_W-1:0] wb_trans_id_i;
  logic [sb_pkg::NR_WB_PORTS-1:0][sb_pkg::XLEN-1:0]  wb_data_i;
  logic                                              commit_valid_o;
  logic [sb_pkg::IDX_W-1:0]                          commit_trans_id_o;
  logic [sb_pkg::REG_ADDR_W-1:0]                     commit_rd_o;
  logic [sb_pkg::FU_W-1:0]                           commit_fu_o;
  logic [sb_pkg::XLEN-1:0]                           commit_result_o;
  logic                                              commit_ack_i;
  logic [sb_pkg::REG_ADDR_W-1:0]                     rs1_i;
  logic [sb_pkg::REG_ADDR_W-1:0]                     rs2_i;
  logic [sb_pkg::XLEN-1:0]                           rs1_o;
  logic                                              rs1_valid_o;
  logic [sb_pkg::XLEN-1:0]                           rs2_o;
  logic                                              rs2_valid_o;
  logic [sb_pkg::NR_REGS-1:0][sb_pkg::FU_W-1:0]      rd_clobber_o;

  // reference model of the queue
  bit                            m_issued [sb_pkg::NR_ENTRIES];
  bit                            m_valid  [sb_pkg::NR_ENTRIES];
  logic [sb_pkg::REG_ADDR_W-1:0] m_rd     [sb_pkg::NR_ENTRIES];
  logic [sb_pkg::FU_W-1:0]       m_fu     [sb_pkg::NR_ENTRIES];
  logic [sb_pkg::XLEN-1:0]       m_result [sb_pkg::NR_ENTRIES];
  logic [sb_pkg::IDX_W-1:0]      m_iptr;
  logic [sb_pkg::IDX_W-1:0]      m_cptr;
  logic [sb_pkg::IDX_W-1:0]      m_cnt;

  logic [31:0] lcg_state;
  int          err_cnt;
  int          cyc_cnt;
  string       test_name;

  scoreboard_top dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------
  function automatic logic [15:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    // upper half, the low bits of an lcg repeat quickly
    return lcg_state[31:16];
  endfunction

  task automatic report_mismatch(input string what, input logic [31:0] exp,
                                 input logic [31:0] act);
    err_cnt++;
    $display("Fail %s %s: expected 0x%0h, actual 0x%0h", test_name, what, exp, act);
  endtask

  task automatic finish_run();
    $display("cycles checked: %0d, errors: %0d", cyc_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  endtask

  task automatic drive_idle();
    flush_i          = 1'b0;
    flush_unissued_i = 1'b0;
    decoded_valid_i  = 1'b0;
    decoded_rd_i     = '0;
    decoded_fu_i     = sb_pkg::FU_NONE;
    issue_ack_i      = 1'b0;
    wb_valid_i       = '0;
    wb_trans_id_i    = '0;
    wb_data_i        = '0;
    commit_ack_i     = 1'b0;
    rs1_i            = '0;
    rs2_i            = '0;
  endtask

  // lowest issued entry that writes the register, x0 never clobbered
  function automatic logic [sb_pkg::FU_W-1:0] clobber_expect(input int reg_idx);
    logic [sb_pkg::FU_W-1:0] fu;
    bit                      found;
    fu    = sb_pkg::FU_NONE;
    found = 1'b0;
    for (int i = 0; i < sb_pkg::NR_ENTRIES; i++) begin
      if (!found && reg_idx != 0 && m_issued[i] && m_rd[i] == reg_idx) begin
        fu    = m_fu[i];
        found = 1'b1;
      end
    end
    return fu;
  endfunction

  // priority: wb port 0, wb port 1, then finished entries by index
  function automatic void fwd_expect(input logic [sb_pkg::REG_ADDR_W-1:0] rs,
                                     output bit v, output logic [sb_pkg::XLEN-1:0] d);
    v = 1'b0;
    d = '0;
    for (int k = 0; k < sb_pkg::NR_WB_PORTS; k++) begin
      if (!v && wb_valid_i[k] && m_rd[wb_trans_id_i[k]] == rs) begin
        v = 1'b1;
        d = wb_data_i[k];
      end
    end
    for (int i = 0; i < sb_pkg::NR_ENTRIES; i++) begin
      if (!v && m_issued[i] && m_valid[i] && m_rd[i] == rs) begin
        v = 1'b1;
        d = m_result[i];
      end
    end
    if (rs == 0) begin
      v = 1'b0;
    end
  endfunction

  // --------------------------------------------------
  // checks and model update
  // --------------------------------------------------
  task automatic check_outputs();
    bit                      full;
    bit                      exp_v;
    logic [sb_pkg::XLEN-1:0] exp_d;
    logic [sb_pkg::FU_W-1:0] exp_fu;
    full = (m_cnt == 3'd7);
    cyc_cnt++;
    if (issue_trans_id_o !== m_iptr) report_mismatch("issue_trans_id_o", m_iptr, issue_trans_id_o);
    if (sb_full_o !== full) report_mismatch("sb_full_o", full, sb_full_o);
    if (decoded_ack_o !== (issue_ack_i & ~full))
      report_mismatch("decoded_ack_o", issue_ack_i & ~full, decoded_ack_o);
    if (issue_valid_o !== (decoded_valid_i & ~full))
      report_mismatch("issue_valid_o", decoded_valid_i & ~full, issue_valid_o);
    if (commit_valid_o !== m_valid[m_cptr])
      report_mismatch("commit_valid_o", m_valid[m_cptr], commit_valid_o);
    if (commit_trans_id_o !== m_cptr) report_mismatch("commit_trans_id_o", m_cptr, commit_trans_id_o);
    // commit fields only mean something for a finished entry
    if (m_valid[m_cptr]) begin
      if (commit_rd_o !== m_rd[m_cptr]) report_mismatch("commit_rd_o", m_rd[m_cptr], commit_rd_o);
      if (commit_fu_o !== m_fu[m_cptr]) report_mismatch("commit_fu_o", m_fu[m_cptr], commit_fu_o);
      if (commit_result_o !== m_result[m_cptr])
        report_mismatch("commit_result_o", m_result[m_cptr], commit_result_o);
    end
    for (int k = 0; k < sb_pkg::NR_REGS; k++) begin
      exp_fu = clobber_expect(k);
      if (rd_clobber_o[k] !== exp_fu)
        report_mismatch($sformatf("rd_clobber_o[%0d]", k), exp_fu, rd_clobber_o[k]);
    end
    fwd_expect(rs1_i, exp_v, exp_d);
    if (rs1_valid_o !== exp_v) report_mismatch("rs1_valid_o", exp_v, rs1_valid_o);
    if (exp_v && rs1_o !== exp_d) report_mismatch("rs1_o", exp_d, rs1_o);
    fwd_expect(rs2_i, exp_v, exp_d);
    if (rs2_valid_o !== exp_v) report_mismatch("rs2_valid_o", exp_v, rs2_valid_o);
    if (exp_v && rs2_o !== exp_d) report_mismatch("rs2_o", exp_d, rs2_o);
  endtask

  task automatic update_model();
    bit                      en;
    bit                      n_issued [sb_pkg::NR_ENTRIES];
    bit                      n_valid  [sb_pkg::NR_ENTRIES];
    logic [sb_pkg::XLEN-1:0] n_result [sb_pkg::NR_ENTRIES];
    en       = decoded_valid_i && issue_ack_i && (m_cnt != 3'd7) && !flush_unissued_i;
    n_issued = m_issued;
    n_valid  = m_valid;
    n_result = m_result;
    if (en) begin
      n_issued[m_iptr] = 1'b1;
      n_valid[m_iptr]  = 1'b0;
      n_result[m_iptr] = '0;
      m_rd[m_iptr]     = decoded_rd_i;
      m_fu[m_iptr]     = decoded_fu_i;
    end
    // entries without a unit finish on their own
    for (int i = 0; i < sb_pkg::NR_ENTRIES; i++) begin
      if (m_issued[i] && m_fu[i] == sb_pkg::FU_NONE) n_valid[i] = 1'b1;
    end
    for (int k = 0; k < sb_pkg::NR_WB_PORTS; k++) begin
      if (wb_valid_i[k] && m_issued[wb_trans_id_i[k]]) begin
        n_valid[wb_trans_id_i[k]]  = 1'b1;
        n_result[wb_trans_id_i[k]] = wb_data_i[k];
      end
    end
    if (commit_ack_i) begin
      n_issued[m_cptr] = 1'b0;
      n_valid[m_cptr]  = 1'b0;
    end
    if (flush_i) begin
      n_issued = '{default: 1'b0};
      n_valid  = '{default: 1'b0};
      m_iptr   = '0;
      m_cptr   = '0;
      m_cnt    = '0;
    end else begin
      m_iptr = m_iptr + en;
      m_cptr = m_cptr + commit_ack_i;
      m_cnt  = m_cnt + en - commit_ack_i;
    end
    m_issued = n_issued;
    m_valid  = n_valid;
    m_result = n_result;
  endtask

  // inputs are already driven at the falling edge, outputs settle by mid cycle
  task automatic run_cycle();
    #10;
    check_outputs();
    update_model();
    @(negedge clk_i);
  endtask

  task automatic wait_flag(input bit full_sel, input string what);
    int n;
    n = 0;
    while ((full_sel ? sb_full_o : commit_valid_o) !== 1'b1 && n < 50) begin
      run_cycle();
      n++;
    end
    if ((full_sel ? sb_full_o : commit_valid_o) !== 1'b1) begin
      err_cnt++;
      $display("Timeout in %s: %s did not rise within 50 cycles", test_name, what);
      finish_run();
    end
  endtask

  // --------------------------------------------------
  // random traffic
  // --------------------------------------------------
  task automatic drive_random();
    logic [15:0] r;
    int          j;
    r                = lcg_next();
    decoded_valid_i  = r[0];
    issue_ack_i      = r[1] | r[2];
    // small register range so forwarding and clobber hits are common
    decoded_rd_i     = {2'b00, r[5:3]};
    decoded_fu_i     = r[8:6] % 6;
    rs1_i            = {2'b00, r[11:9]};
    rs2_i            = {2'b00, r[14:12]};
    r                = lcg_next();
    flush_i          = (r[5:0] == 6'd0);
    flush_unissued_i = (r[9:6] == 4'd1);
    commit_ack_i     = m_valid[m_cptr] & r[10];
    for (int k = 0; k < sb_pkg::NR_WB_PORTS; k++) begin
      r                = lcg_next();
      wb_valid_i[k]    = 1'b0;
      wb_trans_id_i[k] = r[2:0];
      wb_data_i[k]     = {lcg_next(), lcg_next()};
      // only pending entries get a result, and never both ports on one id
      for (int n = 0; n < sb_pkg::NR_ENTRIES && r[3]; n++) begin
        j = (r[2:0] + n) % sb_pkg::NR_ENTRIES;
        if (!wb_valid_i[k] && m_issued[j] && !m_valid[j] && m_fu[j] != sb_pkg::FU_NONE
            && !(k == 1 && wb_valid_i[0] && wb_trans_id_i[0] == j)) begin
          wb_valid_i[k]    = 1'b1;
          wb_trans_id_i[k] = j;
        end
      end
    end
  endtask

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------
  initial begin
    lcg_state = 32'd28;
    err_cnt   = 0;
    cyc_cnt   = 0;
    test_name = "reset";
    m_issued  = '{default: 1'b0};
    m_valid   = '{default: 1'b0};
    m_rd      = '{default: '0};
    m_fu      = '{default: '0};
    m_result  = '{default: '0};
    m_iptr    = '0;
    m_cptr    = '0;
    m_cnt     = '0;
    rst_ni    = 1'b0;
    drive_idle();
    repeat (3) @(negedge clk_i);
    rst_ni = 1'b1;

    // ids count up from 0 until the queue is full
    test_name       = "issue_fill";
    decoded_valid_i = 1'b1;
    issue_ack_i     = 1'b1;
    decoded_fu_i    = sb_pkg::FU_ALU;
    decoded_rd_i    = 5'd3;
    wait_flag(1'b1, "sb_full_o");
    run_cycle();

    test_name       = "flush";
    flush_i         = 1'b1;
    run_cycle();
    drive_idle();
    run_cycle();

    test_name        = "flush_unissued";
    flush_unissued_i = 1'b1;
    decoded_valid_i  = 1'b1;
    issue_ack_i      = 1'b1;
    run_cycle();
    drive_idle();
    run_cycle();

    // no-unit entry finishes early but waits behind entry 0
    test_name       = "fu_none_order";
    decoded_valid_i = 1'b1;
    issue_ack_i     = 1'b1;
    decoded_fu_i    = sb_pkg::FU_ALU;
    decoded_rd_i    = 5'd5;
    rs1_i           = 5'd5;
    rs2_i           = 5'd6;
    run_cycle();
    decoded_fu_i    = sb_pkg::FU_NONE;
    decoded_rd_i    = 5'd6;
    run_cycle();
    decoded_valid_i = 1'b0;
    run_cycle();
    run_cycle();
    wb_valid_i       = 2'b01;
    wb_trans_id_i[0] = 3'd0;
    wb_data_i[0]     = 32'h0000_1234;
    run_cycle();
    wb_valid_i       = '0;
    wait_flag(1'b0, "commit_valid_o");
    commit_ack_i = 1'b1;
    run_cycle();
    commit_ack_i = 1'b0;
    wait_flag(1'b0, "commit_valid_o");
    commit_ack_i = 1'b1;
    run_cycle();
    drive_idle();

    test_name = "random_traffic";
    repeat (2500) begin
      drive_random();
      run_cycle();
    end
    finish_run();
  end

endmodule

//--- verif/sb_asserts.sv
`timescale 1ns/1ns

module sb_asserts (
  input  logic                                              clk_i,
  input  logic                                              rst_ni,
  input  logic                                              flush_i,
  input  logic                                              commit_ack_i,
  input  logic                                              commit_valid_i,
  input  logic                                              sb_full_i,
  input  logic [sb_pkg::FU_W-1:0]                           clobber_x0_i,
  input  logic [sb_pkg::NR_WB_PORTS-1:0]                    wb_valid_i,
  input  logic [sb_pkg::NR_WB_PORTS-1:0][sb_pkg::IDX_W-1:0] wb_trans_id_i
);

  // --------------------------------------------------
  // interface rules
  // --------------------------------------------------
  // the oldest entry must be finished before it retires
  ack_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    commit_ack_i |-> commit_valid_i)
    else $error("commit ack without a valid commit entry");

  // x0 has no producer
  x0_never_clobbered: assert property (@(posedge clk_i) disable iff (!rst_ni)
    clobber_x0_i == sb_pkg::FU_NONE)
    else $error("register 0 reported as clobbered");

  // two results for one id in a cycle is a unit bug
  wb_ids_distinct: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wb_valid_i[0] && wb_valid_i[1]) |-> (wb_trans_id_i[0] != wb_trans_id_i[1]))
    else $error("both write-back ports target the same id");

  // queue empty right after a full flush
  flush_empties: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_i |=> (!sb_full_i && !commit_valid_i))
    else $error("queue not empty after flush");

endmodule

bind scoreboard_top sb_asserts i_sb_asserts (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .flush_i        (flush_i),
  .commit_ack_i   (commit_ack_i),
  .commit_valid_i (commit_valid_o),
  .sb_full_i      (sb_full_o),
  .clobber_x0_i   (rd_clobber_o[0]),
  .wb_valid_i     (wb_valid_i),
  .wb_trans_id_i  (wb_trans_id_i)
);

//--- design/scoreboard_top.sv
`timescale 1ns/1ns

module scoreboard_top (
  input  logic                                              clk_i,
  input  logic                                              rst_ni,
  input  logic                                              flush_i,
  input  logic                                              flush_unissued_i,
  // decoder
  input  logic                                              decoded_valid_i,
  input  logic [sb_pkg::REG_ADDR_W-1:0]                     decoded_rd_i,
  input  logic [sb_pkg::FU_W-1:0]                           decoded_fu_i,
  output logic                                              decoded_ack_o,
  // issue
  output logic                                              issue_valid_o,
  input  logic                                              issue_ack_i,
  output logic [sb_pkg::IDX_W-1:0]                          issue_trans_id_o,
  output logic                                              sb_full_o,
  // write-back
  input  logic [sb_pkg::NR_WB_PORTS-1:0]                    wb_valid_i,
  input  logic [sb_pkg::NR_WB_PORTS-1:0][sb_pkg::IDX_W-1:0] wb_trans_id_i,
  input  logic [sb_pkg::NR_WB_PORTS-1:0][sb_pkg::XLEN-1:0]  wb_data_i,
  // commit
  output logic                                              commit_valid_o,
  output logic [sb_pkg::IDX_W-1:0]                          commit_trans_id_o,
  output logic [sb_pkg::REG_ADDR_W-1:0]                     commit_rd_o,
  output logic [sb_pkg::FU_W-1:0]                           commit_fu_o,
  output logic [sb_pkg::XLEN-1:0]                           commit_result_o,
  input  logic                                              commit_ack_i,
  // operand read
  input  logic [sb_pkg::REG_ADDR_W-1:0]                     rs1_i,
  input  logic [sb_pkg::REG_ADDR_W-1:0]                     rs2_i,
  output logic [sb_pkg::XLEN-1:0]                           rs1_o,
  output logic                                              rs1_valid_o,
  output logic [sb_pkg::XLEN-1:0]                           rs2_o,
  output logic                                              rs2_valid_o,
  // clobber map
  output logic [sb_pkg::NR_REGS-1:0][sb_pkg::FU_W-1:0]      rd_clobber_o
);

  logic                                                  issue_en;
  logic [sb_pkg::NR_ENTRIES-1:0]                         issued;
  logic [sb_pkg::NR_ENTRIES-1:0]                         valid;
  logic [sb_pkg::NR_ENTRIES-1:0][sb_pkg::REG_ADDR_W-1:0] rd;
  logic [sb_pkg::NR_ENTRIES-1:0][sb_pkg::FU_W-1:0]       fu;
  logic [sb_pkg::NR_ENTRIES-1:0][sb_pkg::XLEN-1:0]       result;

  // --------------------------------------------------
  // pointers, count and handshake
  // --------------------------------------------------
  // the pointers double as the issue and commit ids
  sb_queue_ctrl i_queue_ctrl (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .flush_i          (flush_i),
    .flush_unissued_i (flush_unissued_i),
    .decoded_valid_i  (decoded_valid_i),
    .issue_ack_i      (issue_ack_i),
    .commit_ack_i     (commit_ack_i),
    .decoded_ack_o    (decoded_ack_o),
    .issue_valid_o    (issue_valid_o),
    .sb_full_o        (sb_full_o),
    .issue_en_o       (issue_en),
    .issue_ptr_o      (issue_trans_id_o),
    .commit_ptr_o     (commit_trans_id_o)
  );

  // --------------------------------------------------
  // entry storage
  // --------------------------------------------------
  sb_entry_table i_entry_table (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .flush_i         (flush_i),
    .issue_en_i      (issue_en),
    .issue_ptr_i     (issue_trans_id_o),
    .decoded_rd_i    (decoded_rd_i),
    .decoded_fu_i    (decoded_fu_i),
    .commit_ptr_i    (commit_trans_id_o),
    .commit_ack_i    (commit_ack_i),
    .wb_valid_i      (wb_valid_i),
    .wb_trans_id_i   (wb_trans_id_i),
    .wb_data_i       (wb_data_i),
    .issued_o        (issued),
    .valid_o         (valid),
    .rd_o            (rd),
    .fu_o            (fu),
    .result_o        (result),
    .commit_valid_o  (commit_valid_o),
    .commit_rd_o     (commit_rd_o),
    .commit_fu_o     (commit_fu_o),
    .commit_result_o (commit_result_o)
  );

  // --------------------------------------------------
  // table readers
  // --------------------------------------------------
  sb_clobber i_clobber (
    .issued_i     (issued),
    .rd_i         (rd),
    .fu_i         (fu),
    .rd_clobber_o (rd_clobber_o)
  );

  sb_operand_fwd i_operand_fwd (
    .rs1_i         (rs1_i),
    .rs2_i         (rs2_i),
    .wb_valid_i    (wb_valid_i),
    .wb_trans_id_i (wb_trans_id_i),
    .wb_data_i     (wb_data_i),
    .issued_i      (issued),
    .valid_i       (valid),
    .rd_i          (rd),
    .result_i      (result),
    .rs1_o         (rs1_o),
    .rs1_valid_o   (rs1_valid_o),
    .rs2_o         (rs2_o),
    .rs2_valid_o   (rs2_valid_o)
  );

endmodule

//--- design/sb_operand_fwd.sv
`timescale 1ns/1ns

module sb_operand_fwd (
  input  logic [sb_pkg::REG_ADDR_W-1:0]                         rs1_i,
  input  logic [sb_pkg::REG_ADDR_W-1:0]                         rs2_i,
  input  logic [sb_pkg::NR_WB_PORTS-1:0]                        wb_valid_i,
  input  logic [sb_pkg::NR_WB_PORTS-1:0][sb_pkg::IDX_W-1:0]     wb_trans_id_i,
  input  logic [sb_pkg::NR_WB_PORTS-1:0][sb_pkg::XLEN-1:0]      wb_data_i,
  input  logic [sb_pkg::NR_ENTRIES-1:0]                         issued_i,
  input  logic [sb_pkg::NR_ENTRIES-1:0]                         valid_i,
  input  logic [sb_pkg::NR_ENTRIES-1:0][sb_pkg::REG_ADDR_W-1:0] rd_i,
  input  logic [sb_pkg::NR_ENTRIES-1:0][sb_pkg::XLEN-1:0]       result_i,
  output logic [sb_pkg::XLEN-1:0]                               rs1_o,
  output logic                                                  rs1_valid_o,
  output logic [sb_pkg::XLEN-1:0]                               rs2_o,
  output logic                                                  rs2_valid_o
);

  localparam int unsigned NUM_SRC = sb_pkg::NR_WB_PORTS + sb_pkg::NR_ENTRIES;

  // wb ports sit at the low indices, so they take priority
  logic [NUM_SRC-1:0][sb_pkg::XLEN-1:0]   fwd_data;
  // source 0 is rs1, source 1 is rs2
  logic [1:0][sb_pkg::REG_ADDR_W-1:0]     rs_addr;
  logic [1:0][sb_pkg::XLEN-1:0]           rs_data;
  logic [1:0]                             rs_valid;

  assign fwd_data = {result_i, wb_data_i};
  assign rs_addr  = {rs2_i, rs1_i};

  // --------------------------------------------------
  // one selector per read port
  // --------------------------------------------------
  for (genvar s = 0; s < 2; s++) begin : gen_src
    logic [NUM_SRC-1:0] req;
    logic               sel_valid;

    always_comb begin
      // result on the bus this cycle, target entry writes our register
      for (int k = 0; k < sb_pkg::NR_WB_PORTS; k++) begin
        req[k] = wb_valid_i[k] && (rd_i[wb_trans_id_i[k]] == rs_addr[s]);
      end
      // finished entries still waiting for commit
      for (int i = 0; i < sb_pkg::NR_ENTRIES; i++) begin
        req[sb_pkg::NR_WB_PORTS + i] = issued_i[i] && valid_i[i]
                                       && (rd_i[i] == rs_addr[s]);
      end
    end

    sb_prio_select #(
      .NUM_IN (NUM_SRC),
      .DATA_W (sb_pkg::XLEN)
    ) i_sel_rs (
      .req_i   (req),
      .data_i  (fwd_data),
      .valid_o (sel_valid),
      .data_o  (rs_data[s])
    );

    // x0 reads come from the register file, never from here
    assign rs_valid[s] = sel_valid & (|rs_addr[s]);
  end

  assign rs1_o       = rs_data[0];
  assign rs1_valid_o = rs_valid[0];
  assign rs2_o       = rs_data[1];
  assign rs2_valid_o = rs_valid[1];

endmodule

//--- design/sb_clobber.sv
`timescale 1ns/1ns

module sb_clobber (
  input  logic [sb_pkg::NR_ENTRIES-1:0]                         issued_i,
  input  logic [sb_pkg::NR_ENTRIES-1:0][sb_pkg::REG_ADDR_W-1:0] rd_i,
  input  logic [sb_pkg::NR_ENTRIES-1:0][sb_pkg::FU_W-1:0]       fu_i,
  output logic [sb_pkg::NR_REGS-1:0][sb_pkg::FU_W-1:0]          rd_clobber_o
);

  // one extra input at the top carries the default
  logic [sb_pkg::NR_ENTRIES:0][sb_pkg::FU_W-1:0] clobber_fu;

  assign clobber_fu = {sb_pkg::FU_NONE, fu_i};

  // --------------------------------------------------
  // one selector per architectural register
  // --------------------------------------------------
  for (genvar k = 0; k < sb_pkg::NR_REGS; k++) begin : gen_reg
    logic [sb_pkg::NR_ENTRIES:0] req;
    logic                        sel_valid;
    logic [sb_pkg::FU_W-1:0]     sel_fu;

    always_comb begin
      // every live entry that writes register k
      for (int i = 0; i < sb_pkg::NR_ENTRIES; i++) begin
        req[i] = issued_i[i] && (rd_i[i] == sb_pkg::REG_ADDR_W'(k));
      end
      // lowest priority, so it only shows when nothing else hits
      req[sb_pkg::NR_ENTRIES] = 1'b1;
      // x0 is never clobbered
      if (k == 0) begin
        req = '0;
      end
    end

    sb_prio_select #(
      .NUM_IN (sb_pkg::NR_ENTRIES + 1),
      .DATA_W (sb_pkg::FU_W)
    ) i_sel_clobber (
      .req_i   (req),
      .data_i  (clobber_fu),
      .valid_o (sel_valid),
      .data_o  (sel_fu)
    );

    // empty request vector only happens for x0
    assign rd_clobber_o[k] = sel_valid ? sel_fu : sb_pkg::FU_NONE;
  end

endmodule

//--- design/sb_entry_table.sv
`timescale 1ns/1ns

module sb_entry_table (
  input  logic                                              clk_i,
  input  logic                                              rst_ni,
  input  logic                                              flush_i,
  // enqueue side
  input  logic                                              issue_en_i,
  input  logic [sb_pkg::IDX_W-1:0]                          issue_ptr_i,
  input  logic [sb_pkg::REG_ADDR_W-1:0]                     decoded_rd_i,
  input  logic [sb_pkg::FU_W-1:0]                           decoded_fu_i,
  // commit side
  input  logic [sb_pkg::IDX_W-1:0]                          commit_ptr_i,
  input  logic                                              commit_ack_i,
  // write-back ports
  input  logic [sb_pkg::NR_WB_PORTS-1:0]                    wb_valid_i,
  input  logic [sb_pkg::NR_WB_PORTS-1:0][sb_pkg::IDX_W-1:0] wb_trans_id_i,
  input  logic [sb_pkg::NR_WB_PORTS-1:0][sb_pkg::XLEN-1:0]  wb_data_i,
  // whole table, for clobber and forwarding
  output logic [sb_pkg::NR_ENTRIES-1:0]                         issued_o,
  output logic [sb_pkg::NR_ENTRIES-1:0]                         valid_o,
  output logic [sb_pkg::NR_ENTRIES-1:0][sb_pkg::REG_ADDR_W-1:0] rd_o,
  output logic [sb_pkg::NR_ENTRIES-1:0][sb_pkg::FU_W-1:0]       fu_o,
  output logic [sb_pkg::NR_ENTRIES-1:0][sb_pkg::XLEN-1:0]       result_o,
  // oldest entry
  output logic                                              commit_valid_o,
  output logic [sb_pkg::REG_ADDR_W-1:0]                     commit_rd_o,
  output logic [sb_pkg::FU_W-1:0]                           commit_fu_o,
  output logic [sb_pkg::XLEN-1:0]                           commit_result_o
);

  logic [sb_pkg::NR_ENTRIES-1:0]                         issued_q, issued_n;
  logic [sb_pkg::NR_ENTRIES-1:0]                         valid_q, valid_n;
  logic [sb_pkg::NR_ENTRIES-1:0][sb_pkg::REG_ADDR_W-1:0] rd_q, rd_n;
  logic [sb_pkg::NR_ENTRIES-1:0][sb_pkg::FU_W-1:0]       fu_q, fu_n;
  logic [sb_pkg::NR_ENTRIES-1:0][sb_pkg::XLEN-1:0]       result_q, result_n;

  // --------------------------------------------------
  // next state, later updates override earlier ones
  // --------------------------------------------------
  always_comb begin
    issued_n = issued_q;
    valid_n  = valid_q;
    rd_n     = rd_q;
    fu_n     = fu_q;
    result_n = result_q;

    // enqueue: fresh entry, not finished yet
    if (issue_en_i) begin
      issued_n[issue_ptr_i] = 1'b1;
      valid_n[issue_ptr_i]  = 1'b0;
      rd_n[issue_ptr_i]     = decoded_rd_i;
      fu_n[issue_ptr_i]     = decoded_fu_i;
      result_n[issue_ptr_i] = '0;
    end

    // no unit will answer, so the entry completes one cycle after storing
    for (int i = 0; i < sb_pkg::NR_ENTRIES; i++) begin
      if (issued_q[i] && fu_q[i] == sb_pkg::FU_NONE) begin
        valid_n[i] = 1'b1;
      end
    end

    // results only land in live entries
    // a late answer after a flush is dropped here
    for (int k = 0; k < sb_pkg::NR_WB_PORTS; k++) begin
      if (wb_valid_i[k] && issued_q[wb_trans_id_i[k]]) begin
        valid_n[wb_trans_id_i[k]]  = 1'b1;
        result_n[wb_trans_id_i[k]] = wb_data_i[k];
      end
    end

    // retire the oldest entry
    if (commit_ack_i) begin
      issued_n[commit_ptr_i] = 1'b0;
      valid_n[commit_ptr_i]  = 1'b0;
    end

    // full flush wins over everything
    if (flush_i) begin
      issued_n = '0;
      valid_n  = '0;
    end
  end

  // --------------------------------------------------
  // storage
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issued_q <= '0;
      valid_q  <= '0;
      rd_q     <= '0;
      fu_q     <= '0;
      result_q <= '0;
    end else begin
      issued_q <= issued_n;
      valid_q  <= valid_n;
      rd_q     <= rd_n;
      fu_q     <= fu_n;
      result_q <= result_n;
    end
  end

  assign issued_o = issued_q;
  assign valid_o  = valid_q;
  assign rd_o     = rd_q;
  assign fu_o     = fu_q;
  assign result_o = result_q;

  // commit port shows the entry at the commit pointer
  assign commit_valid_o  = valid_q[commit_ptr_i];
  assign commit_rd_o     = rd_q[commit_ptr_i];
  assign commit_fu_o     = fu_q[commit_ptr_i];
  assign commit_result_o = result_q[commit_ptr_i];

endmodule

//--- design/sb_queue_ctrl.sv
`timescale 1ns/1ns

module sb_queue_ctrl (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     flush_i,
  input  logic                     flush_unissued_i,
  input  logic                     decoded_valid_i,
  input  logic                     issue_ack_i,
  input  logic                     commit_ack_i,
  output logic                     decoded_ack_o,
  output logic                     issue_valid_o,
  output logic                     sb_full_o,
  output logic                     issue_en_o,
  output logic [sb_pkg::IDX_W-1:0] issue_ptr_o,
  output logic [sb_pkg::IDX_W-1:0] commit_ptr_o
);

  logic [sb_pkg::IDX_W-1:0] issue_ptr_q;
  logic [sb_pkg::IDX_W-1:0] commit_ptr_q;
  logic [sb_pkg::IDX_W-1:0] cnt_q;
  logic                     full;

  // --------------------------------------------------
  // issue handshake
  // --------------------------------------------------
  // full at count 7, one slot is always kept free
  assign full          = &cnt_q;
  assign sb_full_o     = full;
  assign issue_valid_o = decoded_valid_i & ~full;
  assign decoded_ack_o = issue_ack_i & ~full;

  // nothing is taken in while un-issued work is being dropped
  assign issue_en_o    = decoded_valid_i & decoded_ack_o & ~flush_unissued_i;

  assign issue_ptr_o   = issue_ptr_q;
  assign commit_ptr_o  = commit_ptr_q;

  // --------------------------------------------------
  // pointers and occupancy
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issue_ptr_q  <= '0;
      commit_ptr_q <= '0;
      cnt_q        <= '0;
    end else if (flush_i) begin
      // full flush empties the queue, ids restart at 0
      issue_ptr_q  <= '0;
      commit_ptr_q <= '0;
      cnt_q        <= '0;
    end else begin
      // pointers wrap naturally since the depth is 2**IDX_W
      issue_ptr_q  <= issue_ptr_q + sb_pkg::IDX_W'(issue_en_o);
      commit_ptr_q <= commit_ptr_q + sb_pkg::IDX_W'(commit_ack_i);
      // enqueue and commit in the same cycle cancel out
      cnt_q        <= cnt_q + sb_pkg::IDX_W'(issue_en_o)
                      - sb_pkg::IDX_W'(commit_ack_i);
    end
  end

endmodule

//--- design/sb_prio_select.sv
`timescale 1ns/1ns

module sb_prio_select #(
  parameter int unsigned NUM_IN = 2,
  parameter int unsigned DATA_W = 1
) (
  input  logic [NUM_IN-1:0]             req_i,
  input  logic [NUM_IN-1:0][DATA_W-1:0] data_i,
  output logic                          valid_o,
  output logic [DATA_W-1:0]             data_o
);

  // --------------------------------------------------
  // fixed priority, index 0 wins
  // --------------------------------------------------
  // walk from the top down so the lowest active
  // request is the last one to write data_o
  always_comb begin
    data_o = '0;
    for (int i = NUM_IN - 1; i >= 0; i--) begin
      if (req_i[i]) begin
        data_o = data_i[i];
      end
    end
  end

  // any request at all
  assign valid_o = |req_i;

endmodule

//--- design/sb_pkg.sv
package sb_pkg;

  // --------------------------------------------------
  // queue geometry
  // --------------------------------------------------
  // transaction id width, the depth follows from it
  localparam int unsigned IDX_W       = 3;
  // always a power of two, so the pointers wrap for free
  localparam int unsigned NR_ENTRIES  = 2 ** IDX_W;

  // number of result ports from the functional units
  localparam int unsigned NR_WB_PORTS = 2;

  // --------------------------------------------------
  // register file and datapath
  // --------------------------------------------------
  localparam int unsigned REG_ADDR_W  = 5;
  localparam int unsigned NR_REGS     = 2 ** REG_ADDR_W;
  localparam int unsigned XLEN        = 32;

  // --------------------------------------------------
  // functional unit codes
  // --------------------------------------------------
  localparam int unsigned FU_W        = 3;

  // no write-back expected, entry completes by itself
  localparam logic [FU_W-1:0] FU_NONE  = 3'd0;
  localparam logic [FU_W-1:0] FU_ALU   = 3'd1;
  localparam logic [FU_W-1:0] FU_LOAD  = 3'd2;
  localparam logic [FU_W-1:0] FU_STORE = 3'd3;
  localparam logic [FU_W-1:0] FU_MUL   = 3'd4;
  localparam logic [FU_W-1:0] FU_CSR   = 3'd5;

endpackage
